//--- Bender.yml
package:
  name: game_core

sources:
  - verilog/game_pkg.sv
  - verilog/frame_timer.sv
  - verilog/input_latch.sv
  - verilog/player_logic.sv
  - verilog/dragon_head.sv
  - verilog/collision_detector.sv
  - verilog/game_top.sv
  - target: simulation
    files:
      - tests/game_tb.sv

//--- tb.f
verilog/game_pkg.sv
verilog/frame_timer.sv
verilog/input_latch.sv
verilog/player_logic.sv
verilog/dragon_head.sv
verilog/collision_detector.sv
verilog/game_top.sv
tests/game_tb.sv

//--- tests/game_stim.txt
# buttons udlra, pulse, then expected player xy, sword_visible, sword xy, dragon xy, lives
# positions in hex as xy; the sword tile is ignored while the sword is hidden
10000 0 00 0 00 eb 3
00100 0 00 0 00 eb 3
10001 0 00 0 00 db 3
01001 0 01 1 02 db 3
01100 0 02 0 00 cb 3
01000 1 03 0 00 cb 3
01000 1 04 0 00 bb 3
01000 0 05 0 00 bb 3
01000 0 06 0 00 ab 3
01000 0 07 0 00 ab 3
01000 0 08 0 00 9b 3
01000 0 09 0 00 9b 3
01000 0 0a 0 00 8b 3
01000 0 0b 0 00 8b 3
01001 0 0b 0 00 7b 3
00011 0 1b 1 2b 7b 3
00010 0 2b 0 00 6b 3
00010 0 3b 0 00 6b 3
00010 0 4b 0 00 5b 3
00001 0 4b 1 5b 5b 3
00000 0 4b 0 00 5b 3
00000 0 4b 0 00 4b 2
10000 0 4a 0 00 4b 2
00000 0 4a 0 00 4a 1
00100 1 3a 0 00 4a 1
00000 0 3a 0 00 3a 0
00011 0 3a 0 00 3a 0
10000 0 3a 0 00 3a 0

//--- tests/game_tb.sv
// game core testbench
// replays one stimulus line per frame, checks positions, sword, hit flags and lives

`timescale 1ns/1ps

module game_tb;
    import game_pkg::*;

    localparam int MAX_LINES   = 64;
    localparam int DRIVE_DELAY = 2;  // ns after the rising edge
    localparam int EDGE_FRAMES = GRID_W + 2;  // right edge run, two frames against the wall

    // one frame's expected outputs
    typedef struct packed {
        tile_pos_t player;
        logic      visible;
        tile_pos_t sword;   // only meaningful while visible
        tile_pos_t dragon;
        lives_t    lives;
    } expect_t;

    logic      clk;
    logic      rst_n;
    buttons_t  buttons;
    tile_pos_t player_pos;
    tile_pos_t sword_pos;
    tile_pos_t dragon_pos;
    logic      sword_visible;
    lives_t    lives;
    logic      player_hit;
    logic      sword_hit;
    logic      frame_step;

    buttons_t stim_buttons [MAX_LINES];
    logic     stim_pulse   [MAX_LINES];  // press only for one random cycle
    expect_t  expected     [MAX_LINES];
    int       num_lines;
    int       errors;
    int       cycles;
    int       timeout_cycles;

    game_top game_top_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .buttons       (buttons),
        .player_pos    (player_pos),
        .sword_pos     (sword_pos),
        .sword_visible (sword_visible),
        .dragon_pos    (dragon_pos),
        .lives         (lives),
        .player_hit    (player_hit),
        .sword_hit     (sword_hit),
        .frame_step    (frame_step)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;  // 40 ns period

    // run limit, a few frames of slack over both runs
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (timeout_cycles > 0 && cycles >= timeout_cycles) begin
            $display("timeout: frame steps stopped before the last frame was checked");
            $display("Done: errors found");
            $finish;
        end
    end

    task automatic compare_value(input string name, input logic [7:0] got,
                                 input logic [7:0] want, input string where);
        if (got !== want) begin
            $display("ERR %s %s got %h expected %h", name, where, got, want);
            errors++;
        end
    endtask

    task automatic check_state(input expect_t e, input string where);
        compare_value("player_pos", player_pos, e.player, where);
        compare_value("sword_visible", sword_visible, e.visible, where);
        if (e.visible)
            compare_value("sword_pos", sword_pos, e.sword, where);
        compare_value("dragon_pos", dragon_pos, e.dragon, where);
        compare_value("lives", lives, e.lives, where);
        // hit flags follow straight from the tiles
        compare_value("player_hit", player_hit, e.player == e.dragon, where);
        compare_value("sword_hit", sword_hit, e.visible && e.sword == e.dragon, where);
    endtask

    task automatic read_stim();
        int          fd;
        int          fields;
        string       text;
        logic [4:0]  b;
        logic        p;
        logic        v;
        logic [7:0]  pp;
        logic [7:0]  ss;
        logic [7:0]  dd;
        logic [1:0]  ll;
        fd = $fopen("tests/game_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            errors++;
            return;
        end
        while (!$feof(fd) && num_lines < MAX_LINES) begin
            if ($fgets(text, fd) == 0)
                break;
            if (text.len() < 8 || text[0] == "#")
                continue;  // header or blank line
            fields = $sscanf(text, "%b %b %h %h %h %h %h", b, p, pp, v, ss, dd, ll);
            if (fields != 7) begin
                $display("stimulus line %0d could not be parsed", num_lines);
                errors++;
            end else begin
                stim_buttons[num_lines] = b;
                stim_pulse[num_lines]   = p;
                expected[num_lines]     = {pp, v, ss, dd, ll};
                num_lines++;
            end
        end
        $fclose(fd);
        if (num_lines == 0) begin
            $display("the stimulus file holds no frame lines");
            errors++;
        end
    endtask

    initial begin : main_flow
        int        step_idx;
        int        frame_cycle;  // cycles since the last step
        int        pulse_at;
        int        edge_idx;
        buttons_t  held;
        expect_t   reset_exp;
        tile_pos_t edge_exp;
        rst_n          = 1'b1;
        buttons        = '0;
        errors         = 0;
        cycles         = 0;
        num_lines      = 0;
        timeout_cycles = 0;
        held           = '0;
        void'($urandom(32'hc588));
        reset_exp      = {PLAYER_START, 1'b0, PLAYER_START, DRAGON_START, START_LIVES};

        read_stim();
        timeout_cycles = (num_lines + EDGE_FRAMES + 4) * FRAME_CYCLES + 50;

        repeat (5) @(posedge clk);
        #DRIVE_DELAY rst_n = 1'b0;

        step_idx    = 0;
        frame_cycle = 0;
        pulse_at    = -1;
        // a line's buttons move the player at the next step, seen one step later
        while (step_idx < num_lines + 2) begin
            @(posedge clk);
            #DRIVE_DELAY;
            frame_cycle++;
            if (frame_cycle == pulse_at)
                buttons = held;
            else if (frame_cycle == pulse_at + 1)
                buttons = '0;  // single-cycle press
            if (frame_step) begin
                if (step_idx > 0 && frame_cycle != FRAME_CYCLES) begin
                    $display("ERR frame_step period got %h expected %h",
                             frame_cycle, FRAME_CYCLES);
                    errors++;
                end
                if (step_idx < 2)
                    check_state(reset_exp, "after reset");  // nothing latched yet
                else
                    check_state(expected[step_idx - 2],
                                $sformatf("frame %0d", step_idx - 2));
                frame_cycle = 0;
                pulse_at    = -1;
                if (step_idx < num_lines && stim_pulse[step_idx]) begin
                    held     = stim_buttons[step_idx];
                    buttons  = '0;
                    pulse_at = 1 + ($urandom % 13);  // inside the frame
                end else if (step_idx < num_lines) begin
                    buttons = stim_buttons[step_idx];
                end else begin
                    buttons = '0;
                end
                step_idx++;
            end
        end

        // fresh start, right held until the player sits against the right edge
        rst_n         = 1'b1;
        buttons       = '0;
        buttons.right = 1'b1;
        repeat (5) @(posedge clk);
        #DRIVE_DELAY rst_n = 1'b0;

        edge_idx = 0;
        while (edge_idx < EDGE_FRAMES) begin
            @(posedge clk);
            #DRIVE_DELAY;
            if (frame_step) begin
                // one tile per step, held at the last column
                if (edge_idx < GRID_W)
                    edge_exp.x = coord_t'(edge_idx);
                else
                    edge_exp.x = coord_t'(GRID_W - 1);
                edge_exp.y = '0;
                compare_value("player_pos", player_pos, edge_exp,
                              $sformatf("edge step %0d", edge_idx));
                edge_idx++;
            end
        end

        $display("%0d errors over %0d frames", errors, num_lines);
        if (errors == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

endmodule

//--- verilog/collision_detector.sv
// collision detector
// registered tile compares for dragon against player and sword

`timescale 1ns/1ps

module collision_detector (
    input  logic                clk,
    input  logic                rst_n,
    input  game_pkg::tile_pos_t player_pos,
    input  game_pkg::tile_pos_t sword_pos,
    input  logic                sword_visible,
    input  game_pkg::tile_pos_t dragon_pos,
    output logic                player_hit,
    output logic                sword_hit
);
    logic player_on_dragon;  // same tile, unregistered
    logic sword_on_dragon;

    assign player_on_dragon = (player_pos == dragon_pos);
    // hidden sword is harmless
    assign sword_on_dragon  = sword_visible && (sword_pos == dragon_pos);

    always_ff @(posedge clk) begin
        if (rst_n) begin
            player_hit <= 1'b0;
            sword_hit  <= 1'b0;
        end else begin
            player_hit <= player_on_dragon;  // one cycle behind positions
            sword_hit  <= sword_on_dragon;
        end
    end

endmodule

//--- verilog/dragon_head.sv
// dragon head
// steps one tile toward the player every DRAGON_PERIOD steps
// a fresh sword hit restarts the delay, so the dragon is stunned

`timescale 1ns/1ps

module dragon_head (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                step,
    input  game_pkg::tile_pos_t player_pos,
    input  logic                sword_hit,
    output game_pkg::tile_pos_t dragon_pos
);
    import game_pkg::*;

    logic [$clog2(DRAGON_PERIOD+1)-1:0] delay_cnt;  // steps since last move
    logic                               hit_d;      // delayed sword_hit
    logic                               move;       // this step is a move step

    assign move = step && (delay_cnt == DRAGON_PERIOD - 1);

    always_ff @(posedge clk) begin
        if (rst_n) begin
            delay_cnt  <= '0;
            hit_d      <= 1'b0;
            dragon_pos <= DRAGON_START;
        end else begin
            hit_d <= sword_hit;
            if (sword_hit && !hit_d) begin
                delay_cnt <= '0;  // stunned, full period again
            end else if (move) begin
                delay_cnt <= '0;
            end else if (step) begin
                delay_cnt <= delay_cnt + 1'b1;
            end

            // player_pos still holds the pre-step tile here
            if (move && !(sword_hit && !hit_d)) begin
                if (dragon_pos.x != player_pos.x) begin  // x first
                    if (dragon_pos.x > player_pos.x)
                        dragon_pos.x <= dragon_pos.x - 1'b1;
                    else
                        dragon_pos.x <= dragon_pos.x + 1'b1;
                end else if (dragon_pos.y != player_pos.y) begin
                    if (dragon_pos.y > player_pos.y)
                        dragon_pos.y <= dragon_pos.y - 1'b1;
                    else
                        dragon_pos.y <= dragon_pos.y + 1'b1;
                end
            end
        end
    end

endmodule

//--- verilog/frame_timer.sv
// frame timer
// wrap-around cycle counter, pulses tick once per frame

`timescale 1ns/1ps

module frame_timer (
    input  logic clk,
    input  logic rst_n,
    output logic tick
);
    import game_pkg::*;

    logic [$clog2(FRAME_CYCLES)-1:0] cnt;  // cycle within frame

    always_ff @(posedge clk) begin
        if (rst_n) begin
            cnt  <= '0;
            tick <= 1'b0;
        end else begin
            tick <= (cnt == FRAME_CYCLES - 1);  // registered, lands on the wrap
            if (cnt == FRAME_CYCLES - 1)
                cnt <= '0;
            else
                cnt <= cnt + 1'b1;
        end
    end

    // end-of-frame must be a single pulse
    assert property (@(posedge clk) disable iff (rst_n) tick |=> !tick);

endmodule

//--- verilog/game_pkg.sv
// game core shared definitions
// grid geometry, frame timing, tile positions, buttons and lives

package game_pkg;

    // playfield in tiles
    localparam int GRID_W = 16;  // columns
    localparam int GRID_H = 12;  // rows

    localparam int FRAME_CYCLES  = 16;  // clocks per frame, stands in for vsync
    localparam int DRAGON_PERIOD = 2;   // steps between dragon moves

    typedef logic [3:0] coord_t;  // one tile coordinate

    // one byte, xxxx_yyyy
    typedef struct packed {
        coord_t x;
        coord_t y;
    } tile_pos_t;

    typedef logic [1:0] dir_t;  // facing

    localparam dir_t DIR_UP    = 2'd0;
    localparam dir_t DIR_RIGHT = 2'd1;
    localparam dir_t DIR_DOWN  = 2'd2;
    localparam dir_t DIR_LEFT  = 2'd3;

    // player controls, one bit per button
    typedef struct packed {
        logic up;
        logic down;
        logic left;
        logic right;
        logic attack;
    } buttons_t;

    typedef logic [1:0] lives_t;

    localparam lives_t START_LIVES = 2'd3;

    localparam tile_pos_t PLAYER_START = '{x: 4'd0, y: 4'd0};    // top left
    localparam tile_pos_t DRAGON_START = '{x: 4'd15, y: 4'd11};  // bottom right

endpackage

//--- verilog/game_top.sv
// game core top level
// frame timer, input latch, player, dragon head and collision detector

`timescale 1ns/1ps

module game_top (
    input  logic                clk,
    input  logic                rst_n,
    input  game_pkg::buttons_t  buttons,
    output game_pkg::tile_pos_t player_pos,
    output game_pkg::tile_pos_t sword_pos,
    output logic                sword_visible,
    output game_pkg::tile_pos_t dragon_pos,
    output game_pkg::lives_t    lives,
    output logic                player_hit,
    output logic                sword_hit,
    output logic                frame_step
);
    import game_pkg::*;

    logic     tick;      // end of frame
    buttons_t controls;  // one frame's worth of presses

    frame_timer frame_timer_i (
        .clk   (clk),
        .rst_n (rst_n),
        .tick  (tick)
    );

    input_latch input_latch_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .tick     (tick),
        .buttons  (buttons),
        .controls (controls),
        .step     (frame_step)  // also the observation strobe
    );

    player_logic player_logic_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .step          (frame_step),
        .controls      (controls),
        .player_hit    (player_hit),
        .player_pos    (player_pos),
        .facing        (),  // only used inside for the sword
        .sword_pos     (sword_pos),
        .sword_visible (sword_visible),
        .lives         (lives)
    );

    dragon_head dragon_head_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .step       (frame_step),
        .player_pos (player_pos),
        .sword_hit  (sword_hit),
        .dragon_pos (dragon_pos)
    );

    collision_detector collision_detector_i (
        .clk           (clk),
        .rst_n         (rst_n),
        .player_pos    (player_pos),
        .sword_pos     (sword_pos),
        .sword_visible (sword_visible),
        .dragon_pos    (dragon_pos),
        .player_hit    (player_hit),
        .sword_hit     (sword_hit)
    );

endmodule

//--- verilog/input_latch.sv
// input latch
// gathers button presses over a frame, hands them over on tick
// short presses anywhere in the frame still count for the next step

`timescale 1ns/1ps

module input_latch (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               tick,
    input  game_pkg::buttons_t buttons,
    output game_pkg::buttons_t controls,
    output logic               step
);
    import game_pkg::*;

    buttons_t acc;  // sticky OR of everything seen this frame

    always_ff @(posedge clk) begin
        if (rst_n) begin
            acc      <= '0;
            controls <= '0;
            step     <= 1'b0;
        end else begin
            step <= tick;  // one cycle behind tick, same cycle as new controls
            if (tick) begin
                controls <= acc | buttons;  // include this cycle's presses too
                acc      <= '0;
            end else begin
                acc <= acc | buttons;
            end
        end
    end

endmodule

//--- verilog/player_logic.sv
// player logic
// one tile move per step, facing, sword on the tile ahead
// lives count, one life lost per dragon contact

`timescale 1ns/1ps

module player_logic (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                step,
    input  game_pkg::buttons_t  controls,
    input  logic                player_hit,
    output game_pkg::tile_pos_t player_pos,
    output game_pkg::dir_t      facing,
    output game_pkg::tile_pos_t sword_pos,
    output logic                sword_visible,
    output game_pkg::lives_t    lives
);
    import game_pkg::*;

    tile_pos_t next_pos;     // position after this step
    dir_t      next_facing;
    tile_pos_t ahead_pos;    // tile in front of next_pos
    logic      ahead_ok;     // that tile is on the grid
    logic      hit_d;        // delayed player_hit for edge detect

    // direction priority up, down, left, right; clamp at the edges
    always_comb begin
        next_pos    = player_pos;
        next_facing = facing;  // kept when nothing pressed
        if (controls.up) begin
            next_facing = DIR_UP;
            if (player_pos.y != '0)
                next_pos.y = player_pos.y - 1'b1;  // up lowers y
        end else if (controls.down) begin
            next_facing = DIR_DOWN;
            if (player_pos.y != coord_t'(GRID_H - 1))
                next_pos.y = player_pos.y + 1'b1;
        end else if (controls.left) begin
            next_facing = DIR_LEFT;
            if (player_pos.x != '0)
                next_pos.x = player_pos.x - 1'b1;
        end else if (controls.right) begin
            next_facing = DIR_RIGHT;
            if (player_pos.x != coord_t'(GRID_W - 1))
                next_pos.x = player_pos.x + 1'b1;
        end
    end

    // sword tile, from the new position and facing
    always_comb begin
        ahead_pos = next_pos;
        case (next_facing)
            DIR_UP: begin
                ahead_ok    = (next_pos.y != '0);
                ahead_pos.y = next_pos.y - 1'b1;
            end
            DIR_RIGHT: begin
                ahead_ok    = (next_pos.x != coord_t'(GRID_W - 1));
                ahead_pos.x = next_pos.x + 1'b1;
            end
            DIR_DOWN: begin
                ahead_ok    = (next_pos.y != coord_t'(GRID_H - 1));
                ahead_pos.y = next_pos.y + 1'b1;
            end
            DIR_LEFT: begin
                ahead_ok    = (next_pos.x != '0);
                ahead_pos.x = next_pos.x - 1'b1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst_n) begin
            player_pos    <= PLAYER_START;
            facing        <= DIR_UP;
            sword_pos     <= PLAYER_START;
            sword_visible <= 1'b0;
            lives         <= START_LIVES;
            hit_d         <= 1'b0;
        end else begin
            hit_d <= player_hit;
            if (player_hit && !hit_d && lives != '0)
                lives <= lives - 1'b1;  // once per contact, stops at zero
            if (step) begin
                if (lives != '0) begin
                    player_pos    <= next_pos;
                    facing        <= next_facing;
                    sword_pos     <= ahead_pos;
                    sword_visible <= controls.attack && ahead_ok;  // this frame only
                end else begin
                    sword_visible <= 1'b0;  // game over, frozen
                end
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst_n)
        player_pos.x < GRID_W && player_pos.y < GRID_H);

    // lives only ever go down once out of reset
    assert property (@(posedge clk) disable iff (rst_n) lives <= $past(lives));

endmodule
